/* fwd_params.svh */
`ifndef FWD_PARAMS_SVH
`define FWD_PARAMS_SVH

// Number of filter cores served by the forwarder
`define FWD_N 4

// Word address into one packet buffer, 32 words deep
`define FWD_ADDR_W 5

// Data word width on the read path
`define FWD_DATA_W 64

// Packet length in bytes
`define FWD_PLEN_W 16

// Core index width, also the arbitration tag width
`define FWD_SEL_W 2

`endif

/* fwd_pkg.sv */
`include "fwd_params.svh"

package fwd_pkg;

   // Word address into a packet buffer
   typedef logic [`FWD_ADDR_W-1:0] fwd_addr_t;

   // One packet data word
   typedef logic [`FWD_DATA_W-1:0] fwd_data_t;

   // Packet length in bytes
   typedef logic [`FWD_PLEN_W-1:0] plen_t;

   // Core index and arbitration tag
   typedef logic [`FWD_SEL_W-1:0] core_sel_t;

   // One flag per core
   typedef logic [`FWD_N-1:0] core_vec_t;

   // Read beat returned by a buffer and carried through the mux tree
   typedef struct packed {
      fwd_data_t data;
      logic      vld;
      plen_t     len;
   } fwd_beat_t;

endpackage

/* pkt_buf.sv */
`timescale 1ns/100ps
`include "fwd_params.svh"

module pkt_buf (
   input  logic               clk,
   input  logic               rst,
   // Fill side, stands in for the filter core writer
   input  logic               fill_we,
   input  logic               fill_commit,
   input  fwd_pkg::fwd_addr_t fill_addr,
   input  fwd_pkg::fwd_data_t fill_data,
   input  fwd_pkg::plen_t     fill_len,
   // Read side, driven by the forwarder
   input  fwd_pkg::fwd_addr_t rd_addr,
   input  logic               rd_en,
   output fwd_pkg::fwd_beat_t beat,
   // Arbitration handshake
   output logic               ready,
   input  logic               grant,
   input  logic               release_buf,
   output logic               full
);
   import fwd_pkg::*;

   localparam int DEPTH = 1 << `FWD_ADDR_W;

   // Packet storage
   fwd_data_t mem [DEPTH];

   // Read pipeline stage
   fwd_data_t rd_q;
   logic      rd_vld_q;

   // Committed packet length
   plen_t     len_q;

   // Set by the arbiter ack, cleared by done
   logic      granted;

   logic      fill_ok;

   // Buffer is locked while it holds a packet
   assign fill_ok = ~full;

   always_ff @(posedge clk) begin
      if (fill_we && fill_ok) begin
         mem[fill_addr] <= fill_data;
      end
      if (fill_commit && fill_ok) begin
         len_q <= fill_len;
      end
      // Registered read, one cycle latency
      if (rd_en) begin
         rd_q <= mem[rd_addr];
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         full     <= 1'b0;
         granted  <= 1'b0;
         rd_vld_q <= 1'b0;
      end else begin
         // Only the owning core sees its reads as valid
         rd_vld_q <= rd_en & granted;
         if (release_buf) begin
            full    <= 1'b0;
            granted <= 1'b0;
         end else begin
            if (fill_commit && fill_ok) begin
               full <= 1'b1;
            end
            if (grant) begin
               granted <= 1'b1;
            end
         end
      end
   end

   // Granted core leaves arbitration until released
   assign ready = full & ~granted;

   always_comb begin
      beat.data = rd_q;
      beat.vld  = rd_vld_q;
      beat.len  = len_q;
   end

endmodule

/* tag_tree.sv */
`timescale 1ns/100ps
`include "fwd_params.svh"

module tag_tree (
   input  fwd_pkg::core_vec_t rdy_in,
   input  logic               ack,
   output logic               rdy,
   output fwd_pkg::core_sel_t tag,
   output fwd_pkg::core_vec_t ack_out
);
   import fwd_pkg::*;

   localparam int NPAIR = `FWD_N / 2;

   // Leaf level, one node per pair of cores
   logic [NPAIR-1:0] pair_any;
   logic [NPAIR-1:0] pair_idx;
   logic [NPAIR-1:0] pair_ack;

   // Root level
   logic             root_idx;
   core_sel_t        win_tag;

   for (genvar p = 0; p < NPAIR; p++) begin : g_leaf
      // Either core of the pair can take a packet
      assign pair_any[p] = rdy_in[2*p] | rdy_in[2*p+1];

      // Lower index wins inside the pair
      assign pair_idx[p] = ~rdy_in[2*p];

      // Steer the pair ack to the winning leaf
      assign ack_out[2*p]   = pair_ack[p] & rdy_in[2*p];
      assign ack_out[2*p+1] = pair_ack[p] & ~rdy_in[2*p] & rdy_in[2*p+1];
   end

   // Root picks the lower pair whenever it has a ready core
   assign root_idx = ~pair_any[0];

   assign rdy = |pair_any;

   // Tag is the plain core index of the winner
   assign win_tag = {root_idx, pair_idx[root_idx]};
   assign tag     = win_tag;

   // Ack goes down the same branch the tag came up
   assign pair_ack[0] = ack & pair_any[0];
   assign pair_ack[1] = ack & ~pair_any[0] & pair_any[1];

endmodule

/* mux_tree.sv */
`timescale 1ns/100ps
`include "fwd_params.svh"

module mux_tree (
   input  logic               clk,
   input  logic               rst,
   input  fwd_pkg::core_sel_t sel,
   input  fwd_pkg::fwd_beat_t ins [`FWD_N],
   output fwd_pkg::fwd_beat_t result
);
   import fwd_pkg::*;

   // One select bit per level
   localparam int LEVELS = `FWD_SEL_W;

   // Tree root that feeds the output register
   fwd_beat_t root;

   always_comb begin
      fwd_beat_t node [`FWD_N];
      node = ins;
      // Each level folds neighbouring pairs into the low slots
      for (int l = 0; l < LEVELS; l++) begin
         for (int j = 0; j < (`FWD_N >> (l + 1)); j++) begin
            // Select bit l steers level l with the MSB at the root
            node[j] = sel[l] ? node[2*j+1] : node[2*j];
         end
      end
      root = node[0];
   end

   // Output register clears the valid bit on reset
   always_ff @(posedge clk) begin
      if (rst) begin
         result <= '0;
      end else begin
         result <= root;
      end
   end

endmodule

/* fwd_arb.sv */
`timescale 1ns/100ps
`include "fwd_params.svh"

module fwd_arb (
   input  logic               clk,
   input  logic               rst,
   // Forwarder side
   input  fwd_pkg::fwd_addr_t addr,
   input  logic               rd_en,
   output fwd_pkg::fwd_data_t rd_data,
   output logic               rd_data_vld,
   output fwd_pkg::plen_t     byte_len,
   input  logic               done,
   input  logic               ack,
   output logic               rdy,
   // Core side
   output fwd_pkg::fwd_addr_t fwd_addr,
   output logic               fwd_rd_en,
   input  fwd_pkg::fwd_beat_t fwd_beats [`FWD_N],
   output fwd_pkg::core_vec_t fwd_done,
   input  fwd_pkg::core_vec_t rdy_for_fwd,
   output fwd_pkg::core_vec_t rdy_for_fwd_ack
);
   import fwd_pkg::*;

   // Index offered by the tag tree
   core_sel_t sel_next;

   // Core currently owned by the forwarder
   core_sel_t selection;

   // Registered beat from the selected core
   fwd_beat_t beat_q;

   tag_tree u_tag_tree (
      .rdy_in  (rdy_for_fwd),
      .ack     (ack),
      .rdy     (rdy),
      .tag     (sel_next),
      .ack_out (rdy_for_fwd_ack)
   );

   // Load the selection on a completed rdy/ack handshake
   always_ff @(posedge clk) begin
      if (rst) begin
         selection <= '0;
      end else if (rdy && ack) begin
         selection <= sel_next;
      end
   end

   mux_tree u_mux_tree (
      .clk    (clk),
      .rst    (rst),
      .sel    (selection),
      .ins    (fwd_beats),
      .result (beat_q)
   );

   // Read address and enable go to every buffer
   assign fwd_addr  = addr;
   assign fwd_rd_en = rd_en;

   // done only releases the selected core
   for (genvar i = 0; i < `FWD_N; i++) begin : g_done
      assign fwd_done[i] = done && (selection == core_sel_t'(i));
   end

   // Split the muxed beat onto the forwarder outputs
   assign rd_data     = beat_q.data;
   assign rd_data_vld = beat_q.vld;
   assign byte_len    = beat_q.len;

endmodule

/* fwd_top.sv */
`timescale 1ns/100ps
`include "fwd_params.svh"

module fwd_top (
   input  logic               clk,
   input  logic               rst,
   // Fill port
   input  fwd_pkg::core_sel_t fill_core,
   input  logic               fill_we,
   input  logic               fill_commit,
   input  fwd_pkg::fwd_addr_t fill_addr,
   input  fwd_pkg::fwd_data_t fill_data,
   input  fwd_pkg::plen_t     fill_len,
   output fwd_pkg::core_vec_t full,
   // Forwarder port
   input  fwd_pkg::fwd_addr_t addr,
   input  logic               rd_en,
   input  logic               ack,
   input  logic               done,
   output logic               rdy,
   output fwd_pkg::fwd_data_t rd_data,
   output logic               rd_data_vld,
   output fwd_pkg::plen_t     byte_len
);
   import fwd_pkg::*;

   // Per-core fill strobes
   core_vec_t we_vec;
   core_vec_t commit_vec;

   // Arbitration and release wiring
   core_vec_t ready_vec;
   core_vec_t ack_vec;
   core_vec_t done_vec;

   // Broadcast read port
   fwd_addr_t buf_addr;
   logic      buf_rd_en;

   fwd_beat_t beats [`FWD_N];

   for (genvar i = 0; i < `FWD_N; i++) begin : g_core
      // Decode the fill target
      assign we_vec[i]     = fill_we && (fill_core == core_sel_t'(i));
      assign commit_vec[i] = fill_commit && (fill_core == core_sel_t'(i));

      pkt_buf u_buf (
         .clk         (clk),
         .rst         (rst),
         .fill_we     (we_vec[i]),
         .fill_commit (commit_vec[i]),
         .fill_addr   (fill_addr),
         .fill_data   (fill_data),
         .fill_len    (fill_len),
         .rd_addr     (buf_addr),
         .rd_en       (buf_rd_en),
         .beat        (beats[i]),
         .ready       (ready_vec[i]),
         .grant       (ack_vec[i]),
         .release_buf (done_vec[i]),
         .full        (full[i])
      );
   end

   fwd_arb u_arb (
      .clk             (clk),
      .rst             (rst),
      .addr            (addr),
      .rd_en           (rd_en),
      .rd_data         (rd_data),
      .rd_data_vld     (rd_data_vld),
      .byte_len        (byte_len),
      .done            (done),
      .ack             (ack),
      .rdy             (rdy),
      .fwd_addr        (buf_addr),
      .fwd_rd_en       (buf_rd_en),
      .fwd_beats       (beats),
      .fwd_done        (done_vec),
      .rdy_for_fwd     (ready_vec),
      .rdy_for_fwd_ack (ack_vec)
   );

endmodule

/* tb_fwd_top.sv */
`timescale 1ns/100ps
`include "fwd_params.svh"

module tb_fwd_top;
   import fwd_pkg::*;

   localparam int NROWS    = 5;
   localparam int WAIT_MAX = 64;
   localparam int DEPTH    = 1 << `FWD_ADDR_W;

   logic      clk;
   logic      rst;
   core_sel_t fill_core;
   logic      fill_we;
   logic      fill_commit;
   fwd_addr_t fill_addr;
   fwd_data_t fill_data;
   plen_t     fill_len;
   core_vec_t full;
   fwd_addr_t addr;
   logic      rd_en;
   logic      ack;
   logic      done;
   logic      rdy;
   fwd_data_t rd_data;
   logic      rd_data_vld;
   plen_t     byte_len;

   // Stimulus table, one entry per row in each array
   string     row_name  [NROWS] = '{"single_core0", "single_core2", "four_cores",
                                    "fill_locked", "two_cores_max"};
   core_vec_t row_mask  [NROWS] = '{4'b0001, 4'b0100, 4'b1111, 4'b1110, 4'b1001};
   int        row_words [NROWS] = '{8, 5, 12, 20, 32};
   int        row_drain [NROWS] = '{1, 1, 2, 3, 2};
   // Byte length per core, core 3 in the top field
   logic [`FWD_N-1:0][`FWD_PLEN_W-1:0] row_len [NROWS] = '{
      {16'd0,   16'd0,   16'd0,   16'd61},
      {16'd0,   16'd37,  16'd0,   16'd0},
      {16'd96,  16'd90,  16'd89,  16'd93},
      {16'd155, 16'd150, 16'd157, 16'd0},
      {16'd249, 16'd0,   16'd0,   16'd256}
   };

   // Expected contents of every buffer
   fwd_data_t   model_mem   [`FWD_N][DEPTH];
   plen_t       model_len   [`FWD_N];
   int          model_words [`FWD_N];
   core_vec_t   exp_full;
   logic [31:0] lfsr;

   fwd_top uut (
      .clk         (clk),
      .rst         (rst),
      .fill_core   (fill_core),
      .fill_we     (fill_we),
      .fill_commit (fill_commit),
      .fill_addr   (fill_addr),
      .fill_data   (fill_data),
      .fill_len    (fill_len),
      .full        (full),
      .addr        (addr),
      .rd_en       (rd_en),
      .ack         (ack),
      .done        (done),
      .rdy         (rdy),
      .rd_data     (rd_data),
      .rd_data_vld (rd_data_vld),
      .byte_len    (byte_len)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #10 clk = ~clk;
      end
   end

   task automatic fail_and_stop();
      $display("TEST RESULT: FAIL");
      $fatal(1, "Run stopped at first error");
   endtask

   task automatic check_data(input string name, input fwd_data_t exp, input fwd_data_t act);
      if (act !== exp) begin
         $display("ERR %s expected %h actual %h", name, exp, act);
         fail_and_stop();
      end
   endtask

   task automatic check_len(input string name, input plen_t exp, input plen_t act);
      if (act !== exp) begin
         $display("ERR %s expected %0d actual %0d", name, exp, act);
         fail_and_stop();
      end
   endtask

   task automatic check_vec(input string name, input core_vec_t exp, input core_vec_t act);
      if (act !== exp) begin
         $display("ERR %s expected %b actual %b", name, exp, act);
         fail_and_stop();
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("ERR %s expected %b actual %b", name, exp, act);
         fail_and_stop();
      end
   endtask

   // Galois LFSR, x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 32'h8020_0003;
      end
      return s >> 1;
   endfunction

   // One LFSR step per data bit
   task automatic rand_word(output fwd_data_t w);
      int b;
      for (b = 0; b < `FWD_DATA_W; b++) begin
         lfsr = lfsr_next(lfsr);
         w[b] = lfsr[0];
      end
   endtask

   // Lowest full index is served first
   function automatic int first_full_core(input core_vec_t v);
      int c;
      int idx;
      idx = -1;
      for (c = `FWD_N - 1; c >= 0; c--) begin
         if (v[c]) begin
            idx = c;
         end
      end
      return idx;
   endfunction

   // Write a packet and commit it; a full core must ignore all of it
   task automatic fill_one(input int core, input int words, input plen_t len);
      fwd_data_t w;
      logic      locked;
      int        a;
      locked = exp_full[core];
      for (a = 0; a < words; a++) begin
         rand_word(w);
         @(posedge clk);
         fill_core <= core_sel_t'(core);
         fill_we   <= 1'b1;
         fill_addr <= fwd_addr_t'(a);
         fill_data <= w;
         if (!locked) begin
            model_mem[core][a] = w;
         end
      end
      @(posedge clk);
      fill_we     <= 1'b0;
      fill_commit <= 1'b1;
      fill_len    <= len;
      @(posedge clk);
      fill_commit <= 1'b0;
      if (!locked) begin
         model_len[core]   = len;
         model_words[core] = words;
      end
      exp_full[core] = 1'b1;
   endtask

   task automatic wait_full(input string name);
      int waited;
      waited = 0;
      @(negedge clk);
      while (full !== exp_full) begin
         if (waited == WAIT_MAX) begin
            $display("Timeout: full flags never reached %b during %s", exp_full, name);
            fail_and_stop();
         end
         waited++;
         @(negedge clk);
      end
   endtask

   task automatic wait_rdy(input string name);
      int waited;
      waited = 0;
      @(negedge clk);
      while (rdy !== 1'b1) begin
         if (waited == WAIT_MAX) begin
            $display("Timeout: rdy never rose during %s", name);
            fail_and_stop();
         end
         waited++;
         @(negedge clk);
      end
   endtask

   // Forwarder model: handshake, back to back reads, then done
   task automatic forward_packet(input string name);
      int        core;
      int        words;
      int        cycle;
      logic      vld_exp;
      core_vec_t left;
      core = first_full_core(exp_full);
      if (core < 0) begin
         $display("Table asks to drain a packet but no core is full in %s", name);
         fail_and_stop();
      end
      words = model_words[core];
      wait_rdy(name);
      @(posedge clk);
      ack <= 1'b1;
      // Cycle 0 starts on the handshake edge
      for (cycle = 0; cycle < words + 3; cycle++) begin
         @(posedge clk);
         ack   <= 1'b0;
         rd_en <= (cycle < words);
         if (cycle < words) begin
            addr <= fwd_addr_t'(cycle);
         end
         @(negedge clk);
         // Word issued in cycle n shows up in cycle n+2
         vld_exp = (cycle >= 2) && (cycle - 2 < words);
         check_bit($sformatf("%s rd_data_vld cycle %0d", name, cycle), vld_exp, rd_data_vld);
         if (vld_exp) begin
            check_data($sformatf("%s core %0d word %0d", name, core, cycle - 2),
                       model_mem[core][cycle - 2], rd_data);
         end
         if (cycle >= 2) begin
            check_len($sformatf("%s byte_len core %0d", name, core), model_len[core], byte_len);
         end
      end
      left       = exp_full;
      left[core] = 1'b0;
      // Remaining full cores keep rdy up
      check_bit($sformatf("%s rdy while core %0d held", name, core), left != '0, rdy);
      @(posedge clk);
      done <= 1'b1;
      @(posedge clk);
      done <= 1'b0;
      @(negedge clk);
      exp_full = left;
      check_vec($sformatf("%s full after done core %0d", name, core), exp_full, full);
      check_bit($sformatf("%s rdy after done core %0d", name, core), exp_full != '0, rdy);
   endtask

   initial begin
      int r;
      int c;
      int k;
      rst         = 1'b1;
      fill_core   = '0;
      fill_we     = 1'b0;
      fill_commit = 1'b0;
      fill_addr   = '0;
      fill_data   = '0;
      fill_len    = '0;
      addr        = '0;
      rd_en       = 1'b0;
      ack         = 1'b0;
      done        = 1'b0;
      lfsr        = 32'h3e0946de;
      exp_full    = '0;
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      check_bit("reset rdy", 1'b0, rdy);
      check_bit("reset rd_data_vld", 1'b0, rd_data_vld);
      check_vec("reset full", '0, full);
      for (r = 0; r < NROWS; r++) begin
         for (c = 0; c < `FWD_N; c++) begin
            if (row_mask[r][c]) begin
               fill_one(c, row_words[r], row_len[r][c]);
            end
         end
         wait_full(row_name[r]);
         for (k = 0; k < row_drain[r]; k++) begin
            forward_packet(row_name[r]);
         end
      end
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

/* sim.f */
+incdir+.
fwd_pkg.sv
pkt_buf.sv
tag_tree.sv
mux_tree.sv
fwd_arb.sv
fwd_top.sv
tb_fwd_top.sv

/* Makefile */
# Verilator build and run of the packet forwarding testbench

.PHONY: compile run clean

compile:
	verilator --binary --timing -j 0 --top-module tb_fwd_top -f sim.f

run: compile
	-./obj_dir/Vtb_fwd_top > sim.log 2>&1
	@cat sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" sim.log; then echo "No result in sim.log"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
